// ==== build.f ====
+incdir+source
source/sw_pkg.sv
source/sw_cell.sv
source/sw_array.sv
source/sw_stream_ctrl.sv
source/sw_score_out.sv
source/sw_top_affine.sv
bench/sw_tb.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the Smith-Waterman testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f build.f --top-module sw_tb -Mdir obj_dir -o sw_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sw_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "TESTS FAILED" "$LOG"; then
  exit 1
fi
exit 0

// ==== bench/sw_tb.sv ====
`timescale 1ns/1ps
`include "sw_config.svh"

module sw_tb
  import sw_pkg::*;
();

  localparam int QL           = `SW_QUERY_LENGTH;
  localparam int MAX_DB       = 96;
  localparam int RESET_CYCLES = 5;

  logic        clk;
  logic        rst;
  logic        i_conf;
  logic [31:0] i_count;
  logic [7:0]  i_data;
  logic        i_valid;
  logic [7:0]  o_data;
  logic        o_valid;

  t_base      query_buf [QL];     // cell order, entry 0 sits in cell 0
  t_base      db_buf    [MAX_DB];
  t_score     exp_q [$];
  int         job_q [$];
  int         jobs_sent    = 0;
  int         results_seen = 0;
  int         err_cnt      = 0;
  int         check_cnt    = 0;
  int         cycle_cnt    = 0;
  int         cycle_limit  = RESET_CYCLES + QL + 10; // grows with every job
  logic [7:0] low_byte;
  logic       have_low = 1'b0;

  sw_top_affine dut0 (
    .clk     (clk),
    .rst     (rst),
    .i_conf  (i_conf),
    .i_count (i_count),
    .i_data  (i_data),
    .i_valid (i_valid),
    .o_data  (o_data),
    .o_valid (o_valid)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic int max_int(input int a, input int b);
    return (a > b) ? a : b;
  endfunction

  // Gotoh local alignment, one database column at a time, row 0 is the zero boundary
  function automatic t_score ref_score(input t_base q [QL], input t_base d [MAX_DB],
                                       input int n);
    int h_prev [QL+1];
    int e_prev [QL+1];
    int h_cur  [QL+1];
    int f;
    int e;
    int sub;
    int best;
    best = 0;
    for (int i = 0; i <= QL; i++) begin
      h_prev[i] = 0;
      e_prev[i] = 0;
    end
    for (int j = 0; j < n; j++) begin
      h_cur[0] = 0;
      f = 0;
      for (int i = 1; i <= QL; i++) begin
        e = max_int(0, max_int(h_prev[i] - `SW_GAP_OPEN, e_prev[i] - `SW_GAP_EXTEND));
        f = max_int(0, max_int(h_cur[i-1] - `SW_GAP_OPEN, f - `SW_GAP_EXTEND));
        sub = h_prev[i-1] + ((q[i-1] == d[j]) ? `SW_MATCH : -`SW_MISMATCH);
        h_cur[i] = max_int(max_int(0, sub), max_int(e, f));
        e_prev[i] = e;
        best = max_int(best, h_cur[i]);
      end
      for (int i = 0; i <= QL; i++) begin
        h_prev[i] = h_cur[i];
      end
    end
    return t_score'(best);
  endfunction

  function automatic t_base rand_base();
    return t_base'(2'($urandom));
  endfunction

  task automatic check_score(input t_score got, input t_score expected, input int job);
    check_cnt++;
    if (got !== expected) begin
      err_cnt++;
      $display("mismatch o_data score, job %0d: got 0x%h, expected 0x%h", job, got, expected);
    end
  endtask

  task automatic check_pad(input logic [7:0] hi, input int job);
    check_cnt++;
    if (hi[7:3] !== 5'd0) begin
      err_cnt++;
      $display("mismatch o_data high byte bits 7..3, job %0d: got 0x%h, expected 0x00",
               job, hi[7:3]);
    end
  endtask

  task automatic random_query();
    for (int i = 0; i < QL; i++) begin
      query_buf[i] = rand_base();
    end
  endtask

  task automatic random_db(input int n);
    for (int j = 0; j < n; j++) begin
      db_buf[j] = rand_base();
    end
  endtask

  task automatic drive_byte(input t_base b, input bit gaps);
    if (gaps && ($urandom % 3 == 0)) begin
      i_valid <= 1'b0;
      @(posedge clk);
    end
    i_valid <= 1'b1;
    i_data  <= {6'($urandom), b}; // upper bits carry noise
    @(posedge clk);
  endtask

  task automatic send_job(input int n, input t_score expected, input bit gaps, input bit junk);
    exp_q.push_back(expected);
    job_q.push_back(jobs_sent);
    jobs_sent++;
    cycle_limit += 2 * (QL + n) + QL + 10;
    @(posedge clk);
    i_conf  <= 1'b1;
    i_count <= n;
    @(posedge clk);
    i_conf <= 1'b0;
    for (int i = 0; i < QL; i++) begin
      drive_byte(query_buf[QL-1-i], gaps); // last query base lands in cell 0
    end
    for (int j = 0; j < n; j++) begin
      drive_byte(db_buf[j], gaps);
    end
    i_valid <= junk; // bytes while the score goes out are dropped
    while (results_seen < jobs_sent) begin
      i_data <= 8'($urandom);
      @(posedge clk);
    end
    i_valid <= 1'b0;
    @(posedge clk);
  endtask

  task automatic report_test(input string name, input int jobs, input int err_before);
    $display("test %s: %0d jobs, %0d errors", name, jobs, err_cnt - err_before);
  endtask

  // pair up the two score bytes of each job
  always @(negedge clk) begin
    t_score got;
    if (!rst) begin
      if (o_valid && !have_low) begin
        if (exp_q.size() == 0) begin
          err_cnt++;
          $display("score byte 0x%h arrived while no job was waiting for one", o_data);
        end else begin
          low_byte = o_data;
          have_low = 1'b1;
        end
      end else if (o_valid) begin
        got = t_score'({o_data[2:0], low_byte});
        check_pad(o_data, job_q[0]);
        check_score(got, exp_q[0], job_q[0]);
        void'(exp_q.pop_front());
        void'(job_q.pop_front());
        have_low = 1'b0;
        results_seen++;
      end else if (have_low) begin
        err_cnt++;
        $display("job %0d sent its low score byte without the high byte", job_q[0]);
        void'(exp_q.pop_front());
        void'(job_q.pop_front());
        have_low = 1'b0;
        results_seen++;
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      $display("timeout after %0d cycles, %0d of %0d scores received",
               cycle_cnt, results_seen, jobs_sent);
      $display("TESTS FAILED");
      $finish;
    end
  end

  initial begin
    int n;
    int pre;
    int ins;
    int err_before;
    void'($urandom(76));
    rst     = 1'b1;
    i_conf  = 1'b0;
    i_count = '0;
    i_data  = '0;
    i_valid = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;

    err_before = err_cnt; // query embedded unchanged between random flanks
    random_query();
    pre = int'($urandom % 8);
    n = pre + QL + int'($urandom % 8);
    random_db(n);
    for (int i = 0; i < QL; i++) begin
      db_buf[pre+i] = query_buf[i];
    end
    send_job(n, t_score'(QL * `SW_MATCH), 1'b0, 1'b0);
    report_test("exact match", 1, err_before);

    err_before = err_cnt;
    for (int k = 0; k < 20; k++) begin
      random_query();
      n = 1 + int'($urandom % 64);
      random_db(n);
      send_job(n, ref_score(query_buf, db_buf, n), 1'b0, 1'b0);
    end
    report_test("random jobs", 20, err_before);

    err_before = err_cnt; // query uses A and C only, database G and T only
    for (int k = 0; k < 3; k++) begin
      for (int i = 0; i < QL; i++) begin
        query_buf[i] = t_base'({1'b0, 1'($urandom)});
      end
      n = 1 + int'($urandom % 64);
      for (int j = 0; j < n; j++) begin
        db_buf[j] = t_base'({1'b1, 1'($urandom)});
      end
      send_job(n, t_score'(0), 1'b0, 1'b0);
    end
    report_test("no match", 3, err_before);

    err_before = err_cnt;
    for (int run = 1; run <= 4; run++) begin
      random_query();
      ins = 4 + int'($urandom % 8);
      n = QL + run;
      for (int j = 0; j < n; j++) begin
        if (j < ins) begin
          db_buf[j] = query_buf[j];
        end else if (j < ins + run) begin
          db_buf[j] = rand_base();
        end else begin
          db_buf[j] = query_buf[j-run];
        end
      end
      send_job(n, ref_score(query_buf, db_buf, n), 1'b0, 1'b0);
    end
    report_test("gap scoring", 4, err_before);

    err_before = err_cnt; // each job once dense, once with idle cycles
    for (int k = 0; k < 3; k++) begin
      random_query();
      n = 1 + int'($urandom % 64);
      random_db(n);
      send_job(n, ref_score(query_buf, db_buf, n), 1'b0, 1'b0);
      send_job(n, ref_score(query_buf, db_buf, n), 1'b1, 1'b0);
    end
    report_test("input gaps", 6, err_before);

    err_before = err_cnt;
    for (int k = 0; k < 4; k++) begin
      random_query();
      n = 1 + int'($urandom % 64);
      random_db(n);
      send_job(n, ref_score(query_buf, db_buf, n), 1'b0, 1'b1);
    end
    report_test("back-to-back", 4, err_before);

    repeat (QL + 4) @(posedge clk); // catch stray bytes
    if ((exp_q.size() != 0) || have_low) begin
      err_cnt++;
      $display("%0d jobs still had no complete score at the end", exp_q.size());
    end
    $display("checks %0d, errors %0d, jobs %0d", check_cnt, err_cnt, jobs_sent);
    if (err_cnt == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule : sw_tb

// ==== source/sw_top_affine.sv ====
`timescale 1ns/1ps

module sw_top_affine
  import sw_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        i_conf,
  input  logic [31:0] i_count,
  input  logic [7:0]  i_data,
  input  logic        i_valid,
  output logic [7:0]  o_data,
  output logic        o_valid
);

  logic   query_load;
  t_base  query_base;
  logic   db_valid;
  t_base  db_base;
  logic   db_first;
  logic   db_last;
  logic   done;
  t_score max_score;
  logic   sent;

  sw_stream_ctrl u_decode (
    .clk          (clk),
    .rst          (rst),
    .i_conf       (i_conf),
    .i_count      (i_count),
    .i_data       (i_data),
    .i_valid      (i_valid),
    .i_sent       (sent),
    .o_query_load (query_load),
    .o_query_base (query_base),
    .o_db_valid   (db_valid),
    .o_db_base    (db_base),
    .o_db_first   (db_first),
    .o_db_last    (db_last)
  );

  sw_array u_execute (
    .clk          (clk),
    .rst          (rst),
    .i_query_load (query_load),
    .i_query_base (query_base),
    .i_db_valid   (db_valid),
    .i_db_base    (db_base),
    .i_db_first   (db_first),
    .i_db_last    (db_last),
    .o_done       (done),
    .o_max_score  (max_score)
  );

  sw_score_out u_result (
    .clk         (clk),
    .rst         (rst),
    .i_done      (done),
    .i_max_score (max_score),
    .o_data      (o_data),
    .o_valid     (o_valid),
    .o_sent      (sent)
  );

endmodule : sw_top_affine

// ==== source/sw_score_out.sv ====
`timescale 1ns/1ps

module sw_score_out
  import sw_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       i_done,
  input  t_score     i_max_score,
  output logic [7:0] o_data,
  output logic       o_valid,
  output logic       o_sent
);

  logic [7:0] hi_q;     // upper score bits waiting for the second slot
  logic       second_q; // second byte goes out this cycle

  // low byte the cycle after i_done, high byte right behind it
  always_ff @(posedge clk) begin
    if (rst) begin
      o_valid  <= 1'b0;
      o_sent   <= 1'b0;
      second_q <= 1'b0;
    end else begin
      o_valid  <= i_done | second_q;
      o_sent   <= second_q;
      second_q <= i_done;
    end
  end

  always_ff @(posedge clk) begin
    if (i_done) begin
      o_data <= i_max_score[7:0];
      hi_q   <= 8'(i_max_score >> 8); // zero-extended upper bits
    end else if (second_q) begin
      o_data <= hi_q;
    end
  end

  a_two_bytes : assert property (@(posedge clk) disable iff (rst)
    o_valid ##1 o_valid |=> !o_valid)
    else $error("more than two output bytes in a row");

endmodule : sw_score_out

// ==== source/sw_stream_ctrl.sv ====
`timescale 1ns/1ps
`include "sw_config.svh"

module sw_stream_ctrl
  import sw_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        i_conf,
  input  logic [31:0] i_count,
  input  logic [7:0]  i_data,
  input  logic        i_valid,
  input  logic        i_sent,
  output logic        o_query_load,
  output t_base       o_query_base,
  output logic        o_db_valid,
  output t_base       o_db_base,
  output logic        o_db_first,
  output logic        o_db_last
);

  localparam int QL = `SW_QUERY_LENGTH;
  localparam int QW = $clog2(QL);

  t_state        state;
  logic [QW-1:0] query_cnt;
  logic [31:0]   db_remain;     // database bases still to come
  logic          db_first_pend; // next database base is the first one
  t_base         base_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      state         <= STATE_RST;
      query_cnt     <= '0;
      db_remain     <= '0;
      db_first_pend <= 1'b0;
      o_query_load  <= 1'b0;
      o_db_valid    <= 1'b0;
    end else begin
      o_query_load <= 1'b0;
      o_db_valid   <= 1'b0;
      case (state)
        STATE_RST: if (i_conf) begin
          state         <= STATE_REQ;
          db_remain     <= i_count;
          query_cnt     <= '0;
          db_first_pend <= 1'b1;
        end
        STATE_REQ: if (i_valid) begin
          o_query_load <= 1'b1;
          query_cnt    <= query_cnt + 1'b1;
          if (query_cnt == QW'(QL - 1)) state <= STATE_RUN;
        end
        STATE_RUN: if (i_valid) begin
          o_db_valid    <= 1'b1;
          db_first_pend <= 1'b0;
          db_remain     <= db_remain - 32'd1;
          if (db_remain == 32'd1) state <= STATE_DONE;
        end
        STATE_DONE: if (i_sent) state <= STATE_RST; // bytes here are dropped
        default: state <= STATE_RST;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (i_valid) begin
      base_q     <= t_base'(i_data[1:0]);
      o_db_first <= db_first_pend;
      o_db_last  <= (db_remain == 32'd1);
    end
  end

  assign o_query_base = base_q;
  assign o_db_base    = base_q;

  a_run_has_bases : assert property (@(posedge clk) disable iff (rst)
    (state == STATE_RUN) |-> (db_remain != 32'd0))
    else $error("database phase entered with a zero base count");

  a_conf_when_idle : assert property (@(posedge clk) disable iff (rst)
    i_conf |-> (state == STATE_RST))
    else $error("configuration strobe while a job was still running");

endmodule : sw_stream_ctrl

// ==== source/sw_array.sv ====
`timescale 1ns/1ps
`include "sw_config.svh"

module sw_array
  import sw_pkg::*;
(
  input  logic   clk,
  input  logic   rst,
  input  logic   i_query_load,
  input  t_base  i_query_base,
  input  logic   i_db_valid,
  input  t_base  i_db_base,
  input  logic   i_db_first,
  input  logic   i_db_last,
  output logic   o_done,
  output t_score o_max_score
);

  localparam int QL = `SW_QUERY_LENGTH;

  // index k is the input of cell k, index QL is the end of the chain
  t_base  query_chain [0:QL];
  logic   valid_chain [0:QL];
  t_base  base_chain  [0:QL];
  logic   first_chain [0:QL];
  logic   last_chain  [0:QL];
  t_score h_chain     [0:QL];
  t_score f_chain     [0:QL]; // vertical gap state

  t_score max_q;
  t_score cycle_max;
  logic   chain_busy; // some cell output carries a database base

  // query goes in last base first, so cell 0 ends up with the first query base
  assign query_chain[0] = i_query_base;
  assign valid_chain[0] = i_db_valid;
  assign base_chain[0]  = i_db_base;
  assign first_chain[0] = i_db_first;
  assign last_chain[0]  = i_db_last;
  assign h_chain[0]     = '0;
  assign f_chain[0]     = '0;

  for (genvar k = 0; k < QL; k++) begin : g_cell
    sw_cell u_cell (
      .clk          (clk),
      .rst          (rst),
      .i_query_load (i_query_load),
      .i_query_base (query_chain[k]),
      .i_valid      (valid_chain[k]),
      .i_base       (base_chain[k]),
      .i_first      (first_chain[k]),
      .i_last       (last_chain[k]),
      .i_h_left     (h_chain[k]),
      .i_f_left     (f_chain[k]),
      .o_query_base (query_chain[k+1]),
      .o_valid      (valid_chain[k+1]),
      .o_base       (base_chain[k+1]),
      .o_first      (first_chain[k+1]),
      .o_last       (last_chain[k+1]),
      .o_h          (h_chain[k+1]),
      .o_f          (f_chain[k+1])
    );
  end

  always_comb begin
    cycle_max  = max_q; // includes this cycle's cell outputs
    chain_busy = 1'b0;
    for (int k = 1; k <= QL; k++) begin
      if (valid_chain[k]) begin
        chain_busy = 1'b1;
      end
      if (valid_chain[k] && (h_chain[k] > cycle_max)) begin
        cycle_max = h_chain[k];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      max_q <= '0;
    end else if (i_db_valid && i_db_first) begin
      max_q <= '0; // the previous job has left the array by now
    end else begin
      max_q <= cycle_max;
    end
  end

  assign o_max_score = cycle_max;
  assign o_done      = valid_chain[QL] & last_chain[QL];

  a_clear_when_drained : assert property (@(posedge clk) disable iff (rst)
    (i_db_valid && i_db_first) |-> !chain_busy)
    else $error("max score cleared while a job was still in the array");

endmodule : sw_array

// ==== source/sw_cell.sv ====
`timescale 1ns/1ps
`include "sw_config.svh"

module sw_cell
  import sw_pkg::*;
(
  input  logic   clk,
  input  logic   rst,
  input  logic   i_query_load,
  input  t_base  i_query_base,
  input  logic   i_valid,
  input  t_base  i_base,
  input  logic   i_first,
  input  logic   i_last,
  input  t_score i_h_left,
  input  t_score i_f_left,
  output t_base  o_query_base,
  output logic   o_valid,
  output t_base  o_base,
  output logic   o_first,
  output logic   o_last,
  output t_score o_h,
  output t_score o_f
);

  localparam t_score MATCH    = t_score'(`SW_MATCH);
  localparam t_score MISMATCH = t_score'(`SW_MISMATCH);
  localparam t_score GAP_OPEN = t_score'(`SW_GAP_OPEN);
  localparam t_score GAP_EXT  = t_score'(`SW_GAP_EXTEND);

  t_base  query_q;
  t_score h_q;    // own H, previous database base
  t_score e_q;    // own E, previous database base
  t_score diag_q; // left H, previous database base
  t_score f_q;

  t_score h_prev;
  t_score e_prev;
  t_score diag;
  t_score sub_score;
  t_score e_new;
  t_score f_new;
  t_score h_new;

  function automatic t_score sat_sub(input t_score a, input t_score b);
    return (a > b) ? t_score'(a - b) : '0;
  endfunction

  function automatic t_score max2(input t_score a, input t_score b);
    return (a > b) ? a : b;
  endfunction

  always_comb begin
    h_prev = i_first ? '0 : h_q; // new job starts from an empty column
    e_prev = i_first ? '0 : e_q;
    diag   = i_first ? '0 : diag_q;
    if (i_base == query_q) begin
      sub_score = t_score'(diag + MATCH);
    end else begin
      sub_score = sat_sub(diag, MISMATCH);
    end
    e_new = max2(sat_sub(h_prev, GAP_OPEN), sat_sub(e_prev, GAP_EXT));
    f_new = max2(sat_sub(i_h_left, GAP_OPEN), sat_sub(i_f_left, GAP_EXT));
    h_new = max2(max2(sub_score, e_new), f_new); // zero floor comes from sat_sub
  end

  always_ff @(posedge clk) begin
    if (i_query_load) begin
      query_q <= i_query_base; // shift register along the chain
    end
    if (i_valid) begin
      h_q     <= h_new;
      e_q     <= e_new;
      f_q     <= f_new;
      diag_q  <= i_h_left;
      o_base  <= i_base;
      o_first <= i_first;
      o_last  <= i_last;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      o_valid <= 1'b0;
    end else begin
      o_valid <= i_valid;
    end
  end

  assign o_query_base = query_q;
  assign o_h          = h_q;
  assign o_f          = f_q;

endmodule : sw_cell

// ==== source/sw_pkg.sv ====
`include "sw_config.svh"

package sw_pkg;

  // 2-bit nucleotide codes as carried in i_data[1:0]
  typedef enum logic [1:0] {
    BASE_A = 2'd0,
    BASE_C = 2'd1,
    BASE_G = 2'd2,
    BASE_T = 2'd3
  } t_base;

  // stream control phases
  typedef enum logic [1:0] {
    STATE_RST  = 2'd0, // idle, waiting for i_conf
    STATE_REQ  = 2'd1, // query load
    STATE_RUN  = 2'd2, // database stream
    STATE_DONE = 2'd3  // drain and score output
  } t_state;

  // scores never go below zero
  typedef logic [`SW_SCORE_WIDTH-1:0] t_score;

endpackage : sw_pkg

// ==== source/sw_config.svh ====
`ifndef SW_CONFIG_SVH
`define SW_CONFIG_SVH

// array size, one cell per query base
`define SW_QUERY_LENGTH 16

// width of every H, E, F and max value
`define SW_SCORE_WIDTH 11

// scoring, mismatch and gaps are subtracted
`define SW_MATCH      2
`define SW_MISMATCH   1
`define SW_GAP_OPEN   3 // includes the first gap position
`define SW_GAP_EXTEND 1

`endif
